// ==== bench/tb_la_cpu.sv ====
module tb_la_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    import la_pkg::*;

    localparam logic [31:0] DONE_ADDR      = 32'h0000_03fc;
    localparam int          TIMEOUT_CYCLES = 500;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        inst_en;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;
    logic        ram_we;
    logic        ram_en;
    logic        fill;
    logic        load_we;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic [15:0] lfsr;
    logic [31:0] prog [$];

    la_cpu uut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .inst_i      (inst),
        .ram_data_i  (ram_rdata),
        .inst_addr_o (inst_addr),
        .inst_en_o   (inst_en),
        .ram_addr_o  (ram_addr),
        .ram_data_o  (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_en_o    (ram_en)
    );

    tb_mem_model mem (
        .clk         (clk),
        .inst_addr_i (inst_addr),
        .inst_en_i   (inst_en),
        .inst_o      (inst),
        .ram_en_i    (ram_en),
        .ram_we_i    (ram_we),
        .ram_addr_i  (ram_addr),
        .ram_data_i  (ram_wdata),
        .ram_data_o  (ram_rdata),
        .fill_i      (fill),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] three_reg(input logic [16:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] reg_imm12(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        return {OP_LU12I_W, imm, rd};
    endfunction

    // offsets count words from the branch itself
    function automatic logic [31:0] cond_branch(input logic [5:0] op, input logic [4:0] rj,
                                                input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] jump(input logic [25:0] offs);
        return {OP_B, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem.dmem[addr[9:2]];
    endfunction

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %08h actual %08h", name, exp, act);
            stop_failed();
        end
    endtask

    // lu12i.w + addi.w, the addi immediate is sign-extended
    task automatic load_value(input logic [4:0] rd, output logic [31:0] value);
        logic [31:0] hi;
        logic [31:0] lo;
        take_bits(20, hi);
        take_bits(12, lo);
        prog.push_back(upper_imm(rd, hi[19:0]));
        prog.push_back(reg_imm12(OP_ADDI_W, rd, rd, lo[11:0]));
        value = {hi[19:0], 12'h000} + {{20{lo[11]}}, lo[11:0]};
    endtask

    task automatic add_done_store();
        prog.push_back(reg_imm12(OP_ST_W, 5'd0, 5'd0, DONE_ADDR[11:0]));
    endtask

    task automatic reset_with_program();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        fill = 1'b1;
        @(posedge clk);
        #2;
        fill = 1'b0;
        foreach (prog[i]) begin
            load_we = 1'b1;
            load_addr = 8'(i);
            load_data = prog[i];
            @(posedge clk);
            #2;
        end
        load_we = 1'b0;
        for (int c = 0; c < 16; c++) begin
            assert (!inst_en && !ram_en && !ram_we) else begin
                $display("fetch or data port active while reset is held");
                stop_failed();
            end
            @(posedge clk);
            #2;
        end
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        assert (inst_en) else begin
            $display("fetch not enabled in the first cycle after reset");
            stop_failed();
        end
        check_value("reset pc", RESET_PC, inst_addr);
    endtask

    task automatic wait_done(input string name, input logic [31:0] watch_addr,
                             output int hits);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        hits = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (ram_en && ram_we && ram_addr == watch_addr) begin
                hits++;
            end
            if (ram_en && ram_we && ram_addr == DONE_ADDR) begin
                done = 1'b1;
            end
            cycles++;
        end
        if (!done) begin
            $display("%s: no store to the done address within %0d cycles", name,
                     TIMEOUT_CYCLES);
            stop_failed();
        end
        // let the done store land
        @(posedge clk);
        #2;
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] hi;
        int          hits;
        prog.delete();
        load_value(5'd1, a);
        load_value(5'd2, b);
        take_bits(12, imm);
        take_bits(20, hi);
        prog.push_back(three_reg(OP_ADD_W, 5'd3, 5'd1, 5'd2));
        prog.push_back(three_reg(OP_SUB_W, 5'd4, 5'd1, 5'd2));
        prog.push_back(three_reg(OP_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(three_reg(OP_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(three_reg(OP_XOR, 5'd7, 5'd1, 5'd2));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd8, 5'd1, imm[11:0]));
        prog.push_back(upper_imm(5'd9, hi[19:0]));
        for (int r = 3; r <= 9; r++) begin
            prog.push_back(reg_imm12(OP_ST_W, 5'(r), 5'd0, 12'((r - 3) * 4)));
        end
        add_done_store();
        reset_with_program();
        wait_done("alu", 32'hffff_ffff, hits);
        check_value("alu add.w", a + b, read_word(32'h000));
        check_value("alu sub.w", a - b, read_word(32'h004));
        check_value("alu and", a & b, read_word(32'h008));
        check_value("alu or", a | b, read_word(32'h00c));
        check_value("alu xor", a ^ b, read_word(32'h010));
        check_value("alu addi.w", a + {{20{imm[11]}}, imm[11:0]}, read_word(32'h014));
        check_value("alu lu12i.w", {hi[19:0], 12'h000}, read_word(32'h018));
    endtask

    task automatic test_forward();
        logic [31:0] a;
        logic [31:0] k;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        int          hits;
        prog.delete();
        load_value(5'd1, a);
        take_bits(12, k);
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd2, 5'd1, k[11:0]));
        prog.push_back(three_reg(OP_ADD_W, 5'd3, 5'd2, 5'd1));
        prog.push_back(three_reg(OP_SUB_W, 5'd4, 5'd3, 5'd2));
        prog.push_back(three_reg(OP_XOR, 5'd5, 5'd4, 5'd3));
        prog.push_back(three_reg(OP_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(reg_imm12(OP_ST_W, 5'd6, 5'd0, 12'h020));
        add_done_store();
        reset_with_program();
        wait_done("forward", 32'hffff_ffff, hits);
        v2 = a + {{20{k[11]}}, k[11:0]};
        v3 = v2 + a;
        v4 = v3 - v2;
        v5 = v4 ^ v3;
        check_value("forward chain", v5 | a, read_word(32'h020));
    endtask

    task automatic test_load_use();
        logic [31:0] a;
        logic [31:0] k;
        int          hits;
        prog.delete();
        load_value(5'd1, a);
        take_bits(12, k);
        prog.push_back(reg_imm12(OP_ST_W, 5'd1, 5'd0, 12'h040));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd2, 5'd0, k[11:0]));
        prog.push_back(reg_imm12(OP_LD_W, 5'd3, 5'd0, 12'h040));
        prog.push_back(three_reg(OP_ADD_W, 5'd4, 5'd3, 5'd2));
        prog.push_back(reg_imm12(OP_ST_W, 5'd4, 5'd0, 12'h044));
        // store data taken straight from a load
        prog.push_back(reg_imm12(OP_LD_W, 5'd5, 5'd0, 12'h040));
        prog.push_back(reg_imm12(OP_ST_W, 5'd5, 5'd0, 12'h048));
        add_done_store();
        reset_with_program();
        wait_done("load-use", 32'hffff_ffff, hits);
        check_value("load-use add.w", a + {{20{k[11]}}, k[11:0]}, read_word(32'h044));
        check_value("load-use st.w", a, read_word(32'h048));
    endtask

    task automatic test_branch();
        int hits;
        prog.delete();
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd1, 5'd0, 12'd5));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd2, 5'd0, 12'd5));
        prog.push_back(cond_branch(OP_BEQ, 5'd1, 5'd2, 16'd2));
        prog.push_back(reg_imm12(OP_ST_W, 5'd1, 5'd0, 12'h080));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd3, 5'd0, 12'd7));
        prog.push_back(cond_branch(OP_BNE, 5'd1, 5'd2, 16'd2));
        prog.push_back(reg_imm12(OP_ST_W, 5'd3, 5'd0, 12'h084));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd4, 5'd0, 12'h011));
        prog.push_back(jump(26'd2));
        prog.push_back(reg_imm12(OP_ADDI_W, 5'd4, 5'd0, 12'h022));
        prog.push_back(reg_imm12(OP_ST_W, 5'd4, 5'd0, 12'h08c));
        add_done_store();
        reset_with_program();
        wait_done("branch", 32'h0000_0080, hits);
        assert (hits == 0) else begin
            $display("store behind the taken beq was executed");
            stop_failed();
        end
        check_value("bne fall-through", 32'd7, read_word(32'h084));
        check_value("b target", 32'h0000_0011, read_word(32'h08c));
    endtask

    initial begin
        arst_n = 1'b0;
        fill = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr = 16'd44;
        test_alu();
        test_forward();
        test_load_use();
        test_branch();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== bench/tb_mem_model.sv ====
module tb_mem_model (
    input  logic        clk,
    input  logic [31:0] inst_addr_i,
    input  logic        inst_en_i,
    output logic [31:0] inst_o,
    input  logic        ram_en_i,
    input  logic        ram_we_i,
    input  logic [31:0] ram_addr_i,
    input  logic [31:0] ram_data_i,
    output logic [31:0] ram_data_o,
    input  logic        fill_i,
    input  logic        load_we_i,
    input  logic [7:0]  load_addr_i,
    input  logic [31:0] load_data_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // 1 KiB windows, upper address bits ignored
    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    assign inst_o     = inst_en_i ? imem[inst_addr_i[9:2]] : '0;
    assign ram_data_o = ram_en_i ? dmem[ram_addr_i[9:2]] : '0;

    always_ff @(posedge clk) begin
        if (fill_i) begin
            for (int i = 0; i < 256; i++) begin
                // zero words run as bubbles
                imem[8'(i)] <= '0;
                dmem[8'(i)] <= 32'hdead_0000 | (32'(i) << 2);
            end
        end else begin
            if (load_we_i) begin
                imem[load_addr_i] <= load_data_i;
            end
            if (ram_en_i && ram_we_i) begin
                dmem[ram_addr_i[9:2]] <= ram_data_i;
            end
        end
    end

endmodule

// ==== design/ex_stage.sv ====
module ex_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  la_pkg::alu_op_e           ex_op_i,
    input  logic [la_pkg::XLEN-1:0]   ex_a_i,
    input  logic [la_pkg::XLEN-1:0]   ex_b_i,
    input  logic [la_pkg::XLEN-1:0]   ex_store_data_i,
    input  logic [la_pkg::REG_AW-1:0] ex_rd_i,
    input  logic                      ex_we_i,
    input  logic                      ex_load_i,
    input  logic                      ex_store_i,
    output logic                      fwd_we_o,
    output logic [la_pkg::REG_AW-1:0] fwd_rd_o,
    output logic [la_pkg::XLEN-1:0]   fwd_result_o,
    output logic                      is_load_o,
    output logic [la_pkg::XLEN-1:0]   mem_addr_o,
    output logic [la_pkg::XLEN-1:0]   mem_store_data_o,
    output logic [la_pkg::REG_AW-1:0] mem_rd_o,
    output logic                      mem_we_o,
    output logic                      mem_load_o,
    output logic                      mem_store_o
);
    import la_pkg::*;

    logic [XLEN-1:0] result;

    // also the address for ld.w and st.w
    always_comb begin
        case (ex_op_i)
            ALU_SUB: result = ex_a_i - ex_b_i;
            ALU_AND: result = ex_a_i & ex_b_i;
            ALU_OR:  result = ex_a_i | ex_b_i;
            ALU_XOR: result = ex_a_i ^ ex_b_i;
            ALU_LUI: result = ex_b_i;
            default: result = ex_a_i + ex_b_i;
        endcase
    end

    assign fwd_we_o     = ex_we_i;
    assign fwd_rd_o     = ex_rd_i;
    assign fwd_result_o = result;
    assign is_load_o    = ex_load_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_addr_o       <= '0;
            mem_store_data_o <= '0;
            mem_rd_o         <= '0;
            mem_we_o         <= 1'b0;
            mem_load_o       <= 1'b0;
            mem_store_o      <= 1'b0;
        end else begin
            mem_addr_o       <= result;
            mem_store_data_o <= ex_store_data_i;
            mem_rd_o         <= ex_rd_i;
            mem_we_o         <= ex_we_i;
            mem_load_o       <= ex_load_i;
            mem_store_o      <= ex_store_i;
        end
    end

endmodule

// ==== design/id_stage.sv ====
module id_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [la_pkg::XLEN-1:0]   pc_i,
    input  logic [la_pkg::XLEN-1:0]   inst_i,
    output logic [la_pkg::REG_AW-1:0] rs1_addr_o,
    output logic [la_pkg::REG_AW-1:0] rs2_addr_o,
    input  logic [la_pkg::XLEN-1:0]   rs1_data_i,
    input  logic [la_pkg::XLEN-1:0]   rs2_data_i,
    input  logic                      ex_we_i,
    input  logic [la_pkg::REG_AW-1:0] ex_rd_i,
    input  logic [la_pkg::XLEN-1:0]   ex_result_i,
    input  logic                      ex_is_load_i,
    input  logic                      mem_we_i,
    input  logic [la_pkg::REG_AW-1:0] mem_rd_i,
    input  logic [la_pkg::XLEN-1:0]   mem_result_i,
    output logic                      stall_o,
    output logic                      branch_taken_o,
    output logic [la_pkg::XLEN-1:0]   branch_target_o,
    output la_pkg::alu_op_e           ex_op_o,
    output logic [la_pkg::XLEN-1:0]   ex_a_o,
    output logic [la_pkg::XLEN-1:0]   ex_b_o,
    output logic [la_pkg::XLEN-1:0]   ex_store_data_o,
    output logic [la_pkg::REG_AW-1:0] ex_rd_o,
    output logic                      ex_we_o,
    output logic                      ex_load_o,
    output logic                      ex_store_o
);
    import la_pkg::*;

    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic              is_add, is_sub, is_and, is_or, is_xor;
    logic              is_addi, is_ld, is_st, is_lu12i;
    logic              is_beq, is_bne, is_b;
    logic              is_3r;
    logic              use_rs1;
    logic              use_rs2;
    logic [XLEN-1:0]   si12;
    logic [XLEN-1:0]   offs16;
    logic [XLEN-1:0]   offs26;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   b_val;
    alu_op_e           alu_op;
    logic              taken;

    // execute wins over memory, regfile covers write-back
    function automatic logic [XLEN-1:0] fwd(input logic [REG_AW-1:0] addr,
                                            input logic [XLEN-1:0]   rf_data);
        if (addr != '0 && ex_we_i && ex_rd_i == addr) begin
            return ex_result_i;
        end else if (addr != '0 && mem_we_i && mem_rd_i == addr) begin
            return mem_result_i;
        end
        return rf_data;
    endfunction

    assign rd = inst_i[4:0];
    assign rj = inst_i[9:5];

    assign is_add   = inst_i[31:15] == OP_ADD_W;
    assign is_sub   = inst_i[31:15] == OP_SUB_W;
    assign is_and   = inst_i[31:15] == OP_AND;
    assign is_or    = inst_i[31:15] == OP_OR;
    assign is_xor   = inst_i[31:15] == OP_XOR;
    assign is_addi  = inst_i[31:22] == OP_ADDI_W;
    assign is_ld    = inst_i[31:22] == OP_LD_W;
    assign is_st    = inst_i[31:22] == OP_ST_W;
    assign is_lu12i = inst_i[31:25] == OP_LU12I_W;
    assign is_beq   = inst_i[31:26] == OP_BEQ;
    assign is_bne   = inst_i[31:26] == OP_BNE;
    assign is_b     = inst_i[31:26] == OP_B;

    assign is_3r   = is_add | is_sub | is_and | is_or | is_xor;
    assign use_rs1 = is_3r | is_addi | is_ld | is_st | is_beq | is_bne;
    assign use_rs2 = is_3r | is_st | is_beq | is_bne;

    // store and branches compare or store rd
    assign rs1_addr_o = rj;
    assign rs2_addr_o = is_3r ? inst_i[14:10] : rd;

    assign si12   = {{20{inst_i[21]}}, inst_i[21:10]};
    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    assign op_a = fwd(rs1_addr_o, rs1_data_i);
    assign op_b = fwd(rs2_addr_o, rs2_data_i);

    // load result not ready until memory
    assign stall_o = ex_is_load_i && ex_we_i && ex_rd_i != '0 &&
                     ((use_rs1 && ex_rd_i == rs1_addr_o) ||
                      (use_rs2 && ex_rd_i == rs2_addr_o));

    assign taken = is_b | (is_beq & (op_a == op_b)) | (is_bne & (op_a != op_b));
    assign branch_taken_o  = taken & ~stall_o;
    assign branch_target_o = pc_i + (is_b ? offs26 : offs16);

    always_comb begin
        alu_op = ALU_ADD;
        if (is_sub) begin
            alu_op = ALU_SUB;
        end else if (is_and) begin
            alu_op = ALU_AND;
        end else if (is_or) begin
            alu_op = ALU_OR;
        end else if (is_xor) begin
            alu_op = ALU_XOR;
        end else if (is_lu12i) begin
            alu_op = ALU_LUI;
        end
    end

    assign b_val = is_3r    ? op_b :
                   is_lu12i ? {inst_i[24:5], 12'b0} : si12;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_op_o         <= ALU_ADD;
            ex_a_o          <= '0;
            ex_b_o          <= '0;
            ex_store_data_o <= '0;
            ex_rd_o         <= '0;
            ex_we_o         <= 1'b0;
            ex_load_o       <= 1'b0;
            ex_store_o      <= 1'b0;
        end else begin
            ex_op_o         <= alu_op;
            ex_a_o          <= op_a;
            ex_b_o          <= b_val;
            ex_store_data_o <= op_b;
            ex_rd_o         <= rd;
            // bubble on load-use
            ex_we_o         <= !stall_o && (is_3r | is_addi | is_lu12i | is_ld);
            ex_load_o       <= !stall_o && is_ld;
            ex_store_o      <= !stall_o && is_st;
        end
    end

    a_no_branch_in_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(branch_taken_o && stall_o));

endmodule

// ==== design/if_stage.sv ====
module if_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    stall_i,
    input  logic                    branch_taken_i,
    input  logic [la_pkg::XLEN-1:0] branch_target_i,
    input  logic [la_pkg::XLEN-1:0] inst_i,
    output logic [la_pkg::XLEN-1:0] inst_addr_o,
    output logic                    inst_en_o,
    output logic [la_pkg::XLEN-1:0] id_pc_o,
    output logic [la_pkg::XLEN-1:0] id_inst_o
);
    import la_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            en_q;

    assign inst_addr_o = pc_q;
    assign inst_en_o   = en_q;

    // pc only starts counting once fetch is enabled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
            en_q <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (branch_taken_i) begin
                pc_q <= branch_target_i;
            end else if (en_q && !stall_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    // all-zero word decodes as a bubble
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o   <= '0;
            id_inst_o <= '0;
        end else if (!en_q || branch_taken_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= inst_i;
        end
    end

    // branch targets from decode must keep fetch word-aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

// ==== design/la_cpu.sv ====
module la_cpu (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [la_pkg::XLEN-1:0] inst_i,
    input  logic [la_pkg::XLEN-1:0] ram_data_i,
    output logic [la_pkg::XLEN-1:0] inst_addr_o,
    output logic                    inst_en_o,
    output logic [la_pkg::XLEN-1:0] ram_addr_o,
    output logic [la_pkg::XLEN-1:0] ram_data_o,
    output logic                    ram_we_o,
    output logic                    ram_en_o
);
    import la_pkg::*;

    // decode to fetch
    logic              stall;
    logic              branch_taken;
    logic [XLEN-1:0]   branch_target;

    // fetch to decode
    logic [XLEN-1:0]   id_pc;
    logic [XLEN-1:0]   id_inst;

    // decode and regfile
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;

    // decode to execute
    alu_op_e           ex_op;
    logic [XLEN-1:0]   ex_a;
    logic [XLEN-1:0]   ex_b;
    logic [XLEN-1:0]   ex_store_data;
    logic [REG_AW-1:0] ex_rd;
    logic              ex_we;
    logic              ex_load;
    logic              ex_store;

    // execute forwarding
    logic              ex_fwd_we;
    logic [REG_AW-1:0] ex_fwd_rd;
    logic [XLEN-1:0]   ex_fwd_result;
    logic              ex_is_load;

    // execute to memory
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_store_data;
    logic [REG_AW-1:0] mem_rd;
    logic              mem_we;
    logic              mem_load;
    logic              mem_store;

    // memory forwarding
    logic              mem_fwd_we;
    logic [REG_AW-1:0] mem_fwd_rd;
    logic [XLEN-1:0]   mem_fwd_result;

    // write-back
    logic              wb_we;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;

    if_stage u_if_stage (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .inst_i          (inst_i),
        .inst_addr_o     (inst_addr_o),
        .inst_en_o       (inst_en_o),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    id_stage u_id_stage (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .pc_i            (id_pc),
        .inst_i          (id_inst),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .ex_we_i         (ex_fwd_we),
        .ex_rd_i         (ex_fwd_rd),
        .ex_result_i     (ex_fwd_result),
        .ex_is_load_i    (ex_is_load),
        .mem_we_i        (mem_fwd_we),
        .mem_rd_i        (mem_fwd_rd),
        .mem_result_i    (mem_fwd_result),
        .stall_o         (stall),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_op_o         (ex_op),
        .ex_a_o          (ex_a),
        .ex_b_o          (ex_b),
        .ex_store_data_o (ex_store_data),
        .ex_rd_o         (ex_rd),
        .ex_we_o         (ex_we),
        .ex_load_o       (ex_load),
        .ex_store_o      (ex_store)
    );

    ex_stage u_ex_stage (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .ex_op_i          (ex_op),
        .ex_a_i           (ex_a),
        .ex_b_i           (ex_b),
        .ex_store_data_i  (ex_store_data),
        .ex_rd_i          (ex_rd),
        .ex_we_i          (ex_we),
        .ex_load_i        (ex_load),
        .ex_store_i       (ex_store),
        .fwd_we_o         (ex_fwd_we),
        .fwd_rd_o         (ex_fwd_rd),
        .fwd_result_o     (ex_fwd_result),
        .is_load_o        (ex_is_load),
        .mem_addr_o       (mem_addr),
        .mem_store_data_o (mem_store_data),
        .mem_rd_o         (mem_rd),
        .mem_we_o         (mem_we),
        .mem_load_o       (mem_load),
        .mem_store_o      (mem_store)
    );

    mem_stage u_mem_stage (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .mem_addr_i       (mem_addr),
        .mem_store_data_i (mem_store_data),
        .mem_rd_i         (mem_rd),
        .mem_we_i         (mem_we),
        .mem_load_i       (mem_load),
        .mem_store_i      (mem_store),
        .ram_data_i       (ram_data_i),
        .ram_addr_o       (ram_addr_o),
        .ram_data_o       (ram_data_o),
        .ram_we_o         (ram_we_o),
        .ram_en_o         (ram_en_o),
        .fwd_we_o         (mem_fwd_we),
        .fwd_rd_o         (mem_fwd_rd),
        .fwd_result_o     (mem_fwd_result),
        .wb_we_o          (wb_we),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we),
        .waddr_i  (wb_rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

endmodule

// ==== design/la_pkg.sv ====
package la_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // 3R format, bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 format, bits 31:22
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 1RI20 format, bits 31:25
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // branch formats, bits 31:26
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;
    localparam logic [5:0] OP_B   = 6'h14;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

endpackage

// ==== design/mem_stage.sv ====
module mem_stage (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [la_pkg::XLEN-1:0]   mem_addr_i,
    input  logic [la_pkg::XLEN-1:0]   mem_store_data_i,
    input  logic [la_pkg::REG_AW-1:0] mem_rd_i,
    input  logic                      mem_we_i,
    input  logic                      mem_load_i,
    input  logic                      mem_store_i,
    input  logic [la_pkg::XLEN-1:0]   ram_data_i,
    output logic [la_pkg::XLEN-1:0]   ram_addr_o,
    output logic [la_pkg::XLEN-1:0]   ram_data_o,
    output logic                      ram_we_o,
    output logic                      ram_en_o,
    output logic                      fwd_we_o,
    output logic [la_pkg::REG_AW-1:0] fwd_rd_o,
    output logic [la_pkg::XLEN-1:0]   fwd_result_o,
    output logic                      wb_we_o,
    output logic [la_pkg::REG_AW-1:0] wb_rd_o,
    output logic [la_pkg::XLEN-1:0]   wb_data_o
);
    import la_pkg::*;

    logic [XLEN-1:0] result;

    // word accesses only, no byte lanes
    assign ram_addr_o = mem_addr_i;
    assign ram_data_o = mem_store_data_i;
    assign ram_we_o   = mem_store_i;
    assign ram_en_o   = mem_load_i | mem_store_i;

    // read data comes back in the same cycle
    assign result = mem_load_i ? ram_data_i : mem_addr_i;

    assign fwd_we_o     = mem_we_i;
    assign fwd_rd_o     = mem_rd_i;
    assign fwd_result_o = result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o   <= 1'b0;
            wb_rd_o   <= '0;
            wb_data_o <= '0;
        end else begin
            wb_we_o   <= mem_we_i;
            wb_rd_o   <= mem_rd_i;
            wb_data_o <= result;
        end
    end

    a_we_needs_en: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_we_o |-> ram_en_o);

endmodule

// ==== design/regfile.sv ====
module regfile (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      we_i,
    input  logic [la_pkg::REG_AW-1:0] waddr_i,
    input  logic [la_pkg::XLEN-1:0]   wdata_i,
    input  logic [la_pkg::REG_AW-1:0] raddr1_i,
    input  logic [la_pkg::REG_AW-1:0] raddr2_i,
    output logic [la_pkg::XLEN-1:0]   rdata1_o,
    output logic [la_pkg::XLEN-1:0]   rdata2_o
);
    import la_pkg::*;

    logic [XLEN-1:0] regs [32];

    // r0 is never written and keeps its reset value
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write-back is visible to decode
    assign rdata1_o = (we_i && waddr_i != '0 && waddr_i == raddr1_i) ? wdata_i :
                      regs[raddr1_i];
    assign rdata2_o = (we_i && waddr_i != '0 && waddr_i == raddr2_i) ? wdata_i :
                      regs[raddr2_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
        (raddr1_i == '0) |-> (rdata1_o == '0));

endmodule

// ==== list.f ====
design/la_pkg.sv
design/regfile.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/la_cpu.sv
bench/tb_mem_model.sv
bench/tb_la_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status is the simulation result.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --assert --timescale 1ns/1ps --top-module tb_la_cpu \
    -f list.f -o sim_la_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_la_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
